//--- source/arrayMemory_config.svh
/*
  Geometry of the array memory: 4 arrays of 8 slots with 12-bit elements.
  Data must be at least as wide as a size, because Size and Alloc return their
  values on the data bus.
*/
`ifndef ARRAY_MEMORY_CONFIG_SVH
`define ARRAY_MEMORY_CONFIG_SVH

// ---------------------------------------------------------------------------
// Widths
// ---------------------------------------------------------------------------

`define ARRAY_ADDRESS_BITS 2

`define ARRAY_INDEX_BITS 3

`define ARRAY_DATA_BITS 12

`endif

//--- source/arrayMemoryPkg.sv
/*
  Shared types of the array memory. Opcode encodings are fixed and sparse,
  so a client must use the listed values.
*/
`default_nettype none

`include "arrayMemory_config.svh"

package arrayMemoryPkg;

  localparam int arrayCount = 2 ** `ARRAY_ADDRESS_BITS;   // Arrays in the store
  localparam int slotCount  = 2 ** `ARRAY_INDEX_BITS;     // Slots per array

  // -------------------------------------------------------------------------
  // Request opcodes
  // -------------------------------------------------------------------------
  typedef enum logic [4:0] {
    opResetArrays = 5'd1,                                 // Free every array
    opWrite       = 5'd2,
    opRead        = 5'd3,
    opSize        = 5'd4,
    opPush        = 5'd14,
    opPop         = 5'd15,
    opAlloc       = 5'd18,
    opFree        = 5'd19,
    opAdd         = 5'd20,                                // Returns new value
    opAddAfter    = 5'd21,                                // Returns old value
    opSubtract    = 5'd22,
    opOr          = 5'd28,
    opXor         = 5'd29,
    opAnd         = 5'd30
  } opcodeT;

  typedef enum logic [3:0] {
    errNone         = 4'd0,
    errNotAllocated = 4'd1,                               // Never handed out
    errFreed        = 4'd2,
    errOutOfBounds  = 4'd3,
    errFull         = 4'd4,
    errEmpty        = 4'd5,
    errOutOfMemory  = 4'd6,
    errDoubleFree   = 4'd7
  } errorT;

  typedef logic [`ARRAY_ADDRESS_BITS-1:0] arrayIdT;
  typedef logic [`ARRAY_INDEX_BITS-1:0]   slotT;
  typedef logic [`ARRAY_INDEX_BITS:0]     sizeT;          // Holds a full count
  typedef logic [`ARRAY_DATA_BITS-1:0]    dataT;

endpackage

`default_nettype wire

//--- source/arrayDirectory.sv
/*
  Request check and allocation state. Every request is judged against the
  state before its own update, which lands on the same edge.
  Alloc reuses the newest freed number first, then hands out fresh ones.
*/
`default_nettype none

`include "arrayMemory_config.svh"

module arrayDirectory (
  input  wire                    clock,
  input  wire                    reset,
  input  wire                    requestValid,
  input  arrayMemoryPkg::opcodeT opcode,
  input  arrayMemoryPkg::arrayIdT arrayId,
  input  arrayMemoryPkg::slotT   index,
  input  arrayMemoryPkg::dataT   dataIn,
  output logic                   opValid,
  output arrayMemoryPkg::opcodeT opOpcode,
  output arrayMemoryPkg::arrayIdT opArray,
  output arrayMemoryPkg::slotT   opSlot,
  output arrayMemoryPkg::dataT   opData,
  output arrayMemoryPkg::errorT  opError,
  output logic                   directValid,
  output arrayMemoryPkg::dataT   directData
);

  logic [arrayMemoryPkg::arrayCount-1:0] allocated;      // Live arrays
  arrayMemoryPkg::sizeT    sizes [arrayMemoryPkg::arrayCount];
  arrayMemoryPkg::arrayIdT freeStack [arrayMemoryPkg::arrayCount];
  logic [`ARRAY_ADDRESS_BITS:0] freeTop;                  // Entries on the stack
  logic [`ARRAY_ADDRESS_BITS:0] nextNew;                  // Next never-used number
  logic [`ARRAY_ADDRESS_BITS:0] freeTopLess;
  arrayMemoryPkg::sizeT    currentSize;
  arrayMemoryPkg::sizeT    sizeLess;
  arrayMemoryPkg::errorT   baseError;
  arrayMemoryPkg::errorT   checkError;
  arrayMemoryPkg::arrayIdT allocId;
  arrayMemoryPkg::slotT    resolvedSlot;
  logic                    inBounds;
  logic                    accepted;

  // -------------------------------------------------------------------------
  // Request check
  // -------------------------------------------------------------------------
  always_comb begin
    freeTopLess  = freeTop - 1'b1;
    currentSize  = sizes[arrayId];
    sizeLess     = currentSize - 1'b1;
    inBounds     = {1'b0, index} < currentSize;
    allocId      = nextNew[`ARRAY_ADDRESS_BITS-1:0];
    resolvedSlot = index;
    checkError   = arrayMemoryPkg::errNone;
    if ({1'b0, arrayId} >= nextNew) begin
      baseError = arrayMemoryPkg::errNotAllocated;
    end else if (!allocated[arrayId]) begin
      baseError = arrayMemoryPkg::errFreed;
    end else begin
      baseError = arrayMemoryPkg::errNone;
    end
    case (opcode)
      arrayMemoryPkg::opAlloc: begin
        if (freeTop != '0) begin
          allocId = freeStack[freeTopLess[`ARRAY_ADDRESS_BITS-1:0]];  // Reuse newest freed
        end else if (nextNew >= arrayMemoryPkg::arrayCount) begin
          checkError = arrayMemoryPkg::errOutOfMemory;
        end
      end
      arrayMemoryPkg::opFree: begin
        if (baseError == arrayMemoryPkg::errFreed) checkError = arrayMemoryPkg::errDoubleFree;
        else checkError = baseError;
      end
      arrayMemoryPkg::opWrite, arrayMemoryPkg::opSize: checkError = baseError;
      arrayMemoryPkg::opRead, arrayMemoryPkg::opAdd, arrayMemoryPkg::opAddAfter,
      arrayMemoryPkg::opSubtract, arrayMemoryPkg::opAnd, arrayMemoryPkg::opOr,
      arrayMemoryPkg::opXor: begin
        checkError = baseError;
        if (baseError == arrayMemoryPkg::errNone && !inBounds) begin
          checkError = arrayMemoryPkg::errOutOfBounds;
        end
      end
      arrayMemoryPkg::opPush: begin
        resolvedSlot = currentSize[`ARRAY_INDEX_BITS-1:0];   // Old size is the new top
        checkError   = baseError;
        if (baseError == arrayMemoryPkg::errNone && currentSize[`ARRAY_INDEX_BITS]) begin
          checkError = arrayMemoryPkg::errFull;
        end
      end
      arrayMemoryPkg::opPop: begin
        resolvedSlot = sizeLess[`ARRAY_INDEX_BITS-1:0];
        checkError   = baseError;
        if (baseError == arrayMemoryPkg::errNone && currentSize == '0) begin
          checkError = arrayMemoryPkg::errEmpty;
        end
      end
      default: checkError = arrayMemoryPkg::errNone;
    endcase
  end

  assign accepted = requestValid && checkError == arrayMemoryPkg::errNone;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      opValid   <= 1'b0;
      allocated <= '0;
      freeTop   <= '0;
      nextNew   <= '0;
    end else begin
      opValid <= requestValid;
      if (accepted) begin
        case (opcode)
          arrayMemoryPkg::opResetArrays: begin
            allocated <= '0;
            freeTop   <= '0;
            nextNew   <= '0;
          end
          arrayMemoryPkg::opAlloc: begin
            allocated[allocId] <= 1'b1;
            if (freeTop != '0) freeTop <= freeTopLess;
            else nextNew <= nextNew + 1'b1;
          end
          arrayMemoryPkg::opFree: begin
            allocated[arrayId] <= 1'b0;
            freeTop            <= freeTop + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Sizes, free stack and the stage-one command
  always_ff @(posedge clock) begin
    if (accepted) begin
      case (opcode)
        arrayMemoryPkg::opAlloc: sizes[allocId] <= '0;   // New array starts empty
        arrayMemoryPkg::opFree:  freeStack[freeTop[`ARRAY_ADDRESS_BITS-1:0]] <= arrayId;
        arrayMemoryPkg::opWrite: if (!inBounds) sizes[arrayId] <= {1'b0, index} + 1'b1;
        arrayMemoryPkg::opPush:  sizes[arrayId] <= currentSize + 1'b1;
        arrayMemoryPkg::opPop:   sizes[arrayId] <= sizeLess;
        default: ;
      endcase
    end
    opOpcode    <= opcode;
    opArray     <= (opcode == arrayMemoryPkg::opAlloc) ? allocId : arrayId;
    opSlot      <= resolvedSlot;
    opData      <= dataIn;
    opError     <= checkError;
    directValid <= opcode == arrayMemoryPkg::opAlloc || opcode == arrayMemoryPkg::opSize;
    directData  <= (opcode == arrayMemoryPkg::opAlloc) ? arrayMemoryPkg::dataT'(allocId)
                                                       : arrayMemoryPkg::dataT'(currentSize);
  end

endmodule

`default_nettype wire

//--- source/elementStore.sv
/*
  Element memory of all arrays. Read, modify and write happen in one cycle,
  so a request right behind another sees its write without forwarding.
  Results are combinational and registered by the response stage.
*/
`default_nettype none

module elementStore (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     opValid,
  input  arrayMemoryPkg::opcodeT  opOpcode,
  input  arrayMemoryPkg::arrayIdT opArray,
  input  arrayMemoryPkg::slotT    opSlot,
  input  arrayMemoryPkg::dataT    opData,
  input  arrayMemoryPkg::errorT   opError,
  input  wire                     directValid,
  input  arrayMemoryPkg::dataT    directData,
  output logic                    resultValid,
  output arrayMemoryPkg::dataT    resultData,
  output arrayMemoryPkg::errorT   resultError,
  output logic                    resultDirectValid,
  output arrayMemoryPkg::dataT    resultDirect
);

  arrayMemoryPkg::dataT memory [arrayMemoryPkg::arrayCount][arrayMemoryPkg::slotCount];
  arrayMemoryPkg::dataT oldValue;
  arrayMemoryPkg::dataT newValue;
  logic                 modifies;
  logic                 writeNow;

  assign oldValue = memory[opArray][opSlot];

  always_comb begin
    newValue   = oldValue;
    resultData = '0;                                     // Push, Free, Reset return zero
    modifies   = 1'b0;
    case (opOpcode)
      arrayMemoryPkg::opWrite: begin
        newValue   = opData;
        resultData = opData;
        modifies   = 1'b1;
      end
      arrayMemoryPkg::opPush: begin
        newValue = opData;
        modifies = 1'b1;
      end
      arrayMemoryPkg::opRead, arrayMemoryPkg::opPop: resultData = oldValue;
      arrayMemoryPkg::opAdd, arrayMemoryPkg::opAddAfter: begin
        newValue   = oldValue + opData;                  // Wraps at data width
        resultData = (opOpcode == arrayMemoryPkg::opAdd) ? newValue : oldValue;
        modifies   = 1'b1;
      end
      arrayMemoryPkg::opSubtract: begin
        newValue   = oldValue - opData;
        resultData = newValue;
        modifies   = 1'b1;
      end
      arrayMemoryPkg::opAnd, arrayMemoryPkg::opOr, arrayMemoryPkg::opXor: begin
        if (opOpcode == arrayMemoryPkg::opAnd) newValue = oldValue & opData;
        else if (opOpcode == arrayMemoryPkg::opOr) newValue = oldValue | opData;
        else newValue = oldValue ^ opData;
        resultData = newValue;
        modifies   = 1'b1;
      end
      default: ;
    endcase
  end

  // A command that carries an error leaves the memory unchanged
  assign writeNow = opValid && modifies && opError == arrayMemoryPkg::errNone;

  assign resultValid       = opValid;
  assign resultError       = opError;
  assign resultDirectValid = directValid;
  assign resultDirect      = directData;

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int arrayNum = 0; arrayNum < arrayMemoryPkg::arrayCount; arrayNum++) begin
        for (int slotNum = 0; slotNum < arrayMemoryPkg::slotCount; slotNum++) begin
          memory[arrayNum][slotNum] <= '0;               // Every element starts at zero
        end
      end
    end else if (writeNow) begin
      memory[opArray][opSlot] <= newValue;
    end
  end

endmodule

`default_nettype wire

//--- source/responseStage.sv
/*
  Output register of the response. Data is zero whenever the error code
  is not none, including a failed Alloc.
*/
`default_nettype none

module responseStage (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   resultValid,
  input  arrayMemoryPkg::dataT  resultData,
  input  arrayMemoryPkg::errorT resultError,
  input  wire                   resultDirectValid,
  input  arrayMemoryPkg::dataT  resultDirect,
  output logic                  responseValid,
  output arrayMemoryPkg::dataT  dataOut,
  output arrayMemoryPkg::errorT errorCode
);

  arrayMemoryPkg::dataT chosen;

  // -------------------------------------------------------------------------
  // Data select
  // -------------------------------------------------------------------------
  always_comb begin
    if (resultError != arrayMemoryPkg::errNone) begin
      chosen = '0;                                       // Nothing valid on error
    end else if (resultDirectValid) begin
      chosen = resultDirect;                             // Alloc number or size
    end else begin
      chosen = resultData;
    end
  end

  always_ff @(posedge clock) begin
    dataOut   <= chosen;
    errorCode <= resultError;
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) responseValid <= 1'b0;
    else responseValid <= resultValid;
  end

endmodule

`default_nettype wire

//--- source/arrayMemory.sv
/*
  Allocatable array memory. A request strobe is answered by a response
  strobe exactly two cycles later. A new request may arrive every cycle and
  there is no back-pressure.
*/
`default_nettype none

module arrayMemory (
  input  wire                     clock,
  input  wire                     reset,                 // Active low
  input  wire                     requestValid,
  input  arrayMemoryPkg::opcodeT  opcode,
  input  arrayMemoryPkg::arrayIdT arrayId,
  input  arrayMemoryPkg::slotT    index,
  input  arrayMemoryPkg::dataT    dataIn,
  output logic                    responseValid,
  output arrayMemoryPkg::dataT    dataOut,
  output arrayMemoryPkg::errorT   errorCode
);

  // Stage one command
  logic                    opValid;
  arrayMemoryPkg::opcodeT  opOpcode;
  arrayMemoryPkg::arrayIdT opArray;
  arrayMemoryPkg::slotT    opSlot;
  arrayMemoryPkg::dataT    opData;
  arrayMemoryPkg::errorT   opError;
  logic                    directValid;
  arrayMemoryPkg::dataT    directData;

  // Stage two result
  logic                    resultValid;
  arrayMemoryPkg::dataT    resultData;
  arrayMemoryPkg::errorT   resultError;
  logic                    resultDirectValid;
  arrayMemoryPkg::dataT    resultDirect;

  arrayDirectory u_directory (
    .clock, .reset, .requestValid, .opcode, .arrayId, .index, .dataIn,
    .opValid, .opOpcode, .opArray, .opSlot, .opData, .opError,
    .directValid, .directData
  );

  elementStore u_store (
    .clock, .reset, .opValid, .opOpcode, .opArray, .opSlot, .opData, .opError,
    .directValid, .directData,
    .resultValid, .resultData, .resultError, .resultDirectValid, .resultDirect
  );

  responseStage u_response (
    .clock, .reset, .resultValid, .resultData, .resultError,
    .resultDirectValid, .resultDirect,
    .responseValid, .dataOut, .errorCode
  );

endmodule

`default_nettype wire

//--- bench/arrayMemoryModel.sv
/*
  Reference model of the array memory, updated in request order.
  Element values are known only after a Write or Push to that slot.
*/
`default_nettype none

module arrayMemoryModel;

  localparam int arrays = arrayMemoryPkg::arrayCount;
  localparam int slots  = arrayMemoryPkg::slotCount;

  bit                   live [arrays];
  int                   length [arrays];
  int                   usedCount;                       // Numbers handed out so far
  int                   freeList [$];                    // Last freed is reused first
  arrayMemoryPkg::dataT element [arrays][slots];

  task automatic clearModel();
    usedCount = 0;
    freeList.delete();
    foreach (live[i]) live[i] = 1'b0;
  endtask

  initial clearModel();

  task automatic predict(input arrayMemoryPkg::opcodeT op, input int id, input int idx,
                         input arrayMemoryPkg::dataT din, output arrayMemoryPkg::dataT dout,
                         output arrayMemoryPkg::errorT err);
    arrayMemoryPkg::errorT access;
    arrayMemoryPkg::dataT  old;
    int                    target;
    dout   = '0;
    err    = arrayMemoryPkg::errNone;
    target = 0;
    if (id >= usedCount) access = arrayMemoryPkg::errNotAllocated;
    else if (!live[id]) access = arrayMemoryPkg::errFreed;
    else access = arrayMemoryPkg::errNone;
    case (op)
      arrayMemoryPkg::opResetArrays: clearModel();
      arrayMemoryPkg::opAlloc: begin
        if (freeList.size() > 0) target = freeList.pop_back();
        else if (usedCount < arrays) target = usedCount++;
        else err = arrayMemoryPkg::errOutOfMemory;
        if (err == arrayMemoryPkg::errNone) begin
          live[target]   = 1'b1;
          length[target] = 0;
          dout           = arrayMemoryPkg::dataT'(target);
        end
      end
      arrayMemoryPkg::opFree: begin
        err = (access == arrayMemoryPkg::errFreed) ? arrayMemoryPkg::errDoubleFree : access;
        if (err == arrayMemoryPkg::errNone) begin
          live[id] = 1'b0;
          freeList.push_back(id);
        end
      end
      arrayMemoryPkg::opSize: begin
        err = access;
        if (err == arrayMemoryPkg::errNone) dout = arrayMemoryPkg::dataT'(length[id]);
      end
      arrayMemoryPkg::opWrite: begin
        err = access;
        if (err == arrayMemoryPkg::errNone) begin
          element[id][idx] = din;
          if (idx >= length[id]) length[id] = idx + 1;   // Grows to cover the index
          dout = din;
        end
      end
      arrayMemoryPkg::opPush: begin
        err = access;
        if (err == arrayMemoryPkg::errNone && length[id] == slots) err = arrayMemoryPkg::errFull;
        if (err == arrayMemoryPkg::errNone) element[id][length[id]++] = din;
      end
      arrayMemoryPkg::opPop: begin
        err = access;
        if (err == arrayMemoryPkg::errNone && length[id] == 0) err = arrayMemoryPkg::errEmpty;
        if (err == arrayMemoryPkg::errNone) dout = element[id][--length[id]];
      end
      default: begin                                     // Read and arithmetic
        err = access;
        if (err == arrayMemoryPkg::errNone && idx >= length[id]) begin
          err = arrayMemoryPkg::errOutOfBounds;
        end
        if (err == arrayMemoryPkg::errNone) begin
          old = element[id][idx];
          case (op)
            arrayMemoryPkg::opAdd, arrayMemoryPkg::opAddAfter: element[id][idx] = old + din;
            arrayMemoryPkg::opSubtract: element[id][idx] = old - din;
            arrayMemoryPkg::opAnd: element[id][idx] = old & din;
            arrayMemoryPkg::opOr:  element[id][idx] = old | din;
            arrayMemoryPkg::opXor: element[id][idx] = old ^ din;
            default: ;
          endcase
          dout = (op == arrayMemoryPkg::opAddAfter) ? old : element[id][idx];
        end
      end
    endcase
  endtask

endmodule

`default_nettype wire

//--- bench/arrayMemoryBench.sv
/*
  Testbench of the array memory. Outputs are checked at the falling edge,
  where they are stable, against expected responses queued at request time.
*/
`default_nettype none

module arrayMemoryBench;

  localparam int clockPeriod    = 40;
  localparam int driveDelay     = 5;                     // After the rising edge
  localparam int resetCycles    = 8;
  localparam int randomRequests = 120;
  localparam int watchdogCycles = resetCycles + 70 + randomRequests + 50;

  logic                    clock;
  logic                    reset;
  logic                    requestValid;
  arrayMemoryPkg::opcodeT  opcode;
  arrayMemoryPkg::arrayIdT arrayId;
  arrayMemoryPkg::slotT    index;
  arrayMemoryPkg::dataT    dataIn;
  logic                    responseValid;
  arrayMemoryPkg::dataT    dataOut;
  arrayMemoryPkg::errorT   errorCode;
  arrayMemoryPkg::dataT    expectData [$];
  arrayMemoryPkg::errorT   expectError [$];
  arrayMemoryPkg::dataT    headData;                     // Expected for current response
  arrayMemoryPkg::errorT   headError;
  logic                    headPresent;

  arrayMemory u_dut (
    .clock, .reset, .requestValid, .opcode, .arrayId, .index, .dataIn,
    .responseValid, .dataOut, .errorCode
  );

  arrayMemoryModel refModel ();

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic sendRequest(input arrayMemoryPkg::opcodeT op, input int id, input int idx,
                             input arrayMemoryPkg::dataT din);
    arrayMemoryPkg::dataT  expData;
    arrayMemoryPkg::errorT expErr;
    refModel.predict(op, id, idx, din, expData, expErr);
    expectData.push_back(expData);
    expectError.push_back(expErr);
    requestValid = 1'b1;
    opcode       = op;
    arrayId      = arrayMemoryPkg::arrayIdT'(id);
    index        = arrayMemoryPkg::slotT'(idx);
    dataIn       = din;
    @(posedge clock);
    #driveDelay;
    requestValid = 1'b0;
  endtask

  function automatic arrayMemoryPkg::opcodeT arithmeticOp(input int unsigned pick);
    case (pick % 6)
      0: return arrayMemoryPkg::opAdd;
      1: return arrayMemoryPkg::opAddAfter;
      2: return arrayMemoryPkg::opSubtract;
      3: return arrayMemoryPkg::opAnd;
      4: return arrayMemoryPkg::opOr;
      default: return arrayMemoryPkg::opXor;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Response checks
  // --------------------------------------------------------------------------
  always @(posedge clock) begin
    #1;
    if (responseValid) begin
      headPresent = expectData.size() > 0;
      if (headPresent) begin
        headData  = expectData.pop_front();
        headError = expectError.pop_front();
      end
    end
  end

  // Two register stages from request to response
  assert property (@(negedge clock) disable iff (!reset) responseValid == $past(requestValid, 2))
    else stopWithFailure($sformatf("Error responseValid expected %h got %h",
                                   !responseValid, responseValid));
  assert property (@(negedge clock) disable iff (!reset) responseValid |-> headPresent)
    else stopWithFailure("A response arrived with no request outstanding");
  assert property (@(negedge clock) disable iff (!reset) responseValid |-> dataOut == headData)
    else stopWithFailure($sformatf("Error dataOut expected %h got %h", headData, dataOut));
  assert property (@(negedge clock) disable iff (!reset)
                   responseValid |-> errorCode == headError)
    else stopWithFailure($sformatf("Error errorCode expected %h got %h", headError, errorCode));

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  initial begin
    #(watchdogCycles * clockPeriod);
    stopWithFailure("Watchdog expired before the test sequence finished");
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    void'($urandom(32'hafc6));
    reset        = 1'b0;
    requestValid = 1'b0;
    opcode       = arrayMemoryPkg::opRead;
    arrayId      = '0;
    index        = '0;
    dataIn       = '0;
    headData     = '0;
    headError    = arrayMemoryPkg::errNone;
    headPresent  = 1'b0;
    repeat (resetCycles) @(posedge clock);
    #driveDelay;
    reset = 1'b1;
    repeat (3) @(posedge clock);                         // Idle, nothing may answer
    #driveDelay;

    sendRequest(arrayMemoryPkg::opRead, 0, 0, '0);       // Never allocated
    repeat (5) sendRequest(arrayMemoryPkg::opAlloc, 0, 0, '0);
    sendRequest(arrayMemoryPkg::opFree, 2, 0, '0);
    sendRequest(arrayMemoryPkg::opFree, 1, 0, '0);
    repeat (2) sendRequest(arrayMemoryPkg::opAlloc, 0, 0, '0);
    repeat (2) sendRequest(arrayMemoryPkg::opFree, 3, 0, '0);
    sendRequest(arrayMemoryPkg::opAlloc, 0, 0, '0);

    for (int i = 0; i < 4; i++) begin
      sendRequest(arrayMemoryPkg::opWrite, 0, i, arrayMemoryPkg::dataT'($urandom));
      sendRequest(arrayMemoryPkg::opRead, 0, i, '0);
    end
    sendRequest(arrayMemoryPkg::opSize, 0, 0, '0);
    sendRequest(arrayMemoryPkg::opRead, 0, 4, '0);       // At the size
    sendRequest(arrayMemoryPkg::opRead, 0, 7, '0);
    sendRequest(arrayMemoryPkg::opFree, 1, 0, '0);
    sendRequest(arrayMemoryPkg::opRead, 1, 0, '0);
    sendRequest(arrayMemoryPkg::opWrite, 1, 2, '0);
    sendRequest(arrayMemoryPkg::opAlloc, 0, 0, '0);

    // Stack on array 2, one step past each limit
    for (int i = 0; i <= arrayMemoryPkg::slotCount; i++) begin
      sendRequest(arrayMemoryPkg::opPush, 2, 0, arrayMemoryPkg::dataT'($urandom));
    end
    sendRequest(arrayMemoryPkg::opSize, 2, 0, '0);
    for (int i = 0; i <= arrayMemoryPkg::slotCount; i++) begin
      sendRequest(arrayMemoryPkg::opPop, 2, 0, '0);
    end

    // Back-to-back arithmetic on three slots of array 3
    for (int i = 0; i < 3; i++) begin
      sendRequest(arrayMemoryPkg::opWrite, 3, i, arrayMemoryPkg::dataT'($urandom));
    end
    for (int i = 0; i < randomRequests; i++) begin
      sendRequest(arithmeticOp($urandom), 3, $urandom % 3, arrayMemoryPkg::dataT'($urandom));
    end
    for (int i = 0; i < 3; i++) begin
      sendRequest(arrayMemoryPkg::opRead, 3, i, '0);
    end

    sendRequest(arrayMemoryPkg::opResetArrays, 0, 0, '0);
    sendRequest(arrayMemoryPkg::opRead, 0, 0, '0);
    sendRequest(arrayMemoryPkg::opAlloc, 0, 0, '0);

    repeat (5) @(posedge clock);                         // Drain the pipeline
    if (expectData.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      stopWithFailure("Responses still outstanding at the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/arrayMemoryPkg.sv
source/arrayDirectory.sv
source/elementStore.sv
source/responseStage.sv
source/arrayMemory.sv
bench/arrayMemoryModel.sv
bench/arrayMemoryBench.sv

//--- Makefile
# Verilator build and run of the array memory testbench

VERILATOR ?= verilator
TOP       ?= arrayMemoryBench
RTL_TOP   ?= arrayMemory
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
